/* Makefile */
# Verilator build and run of the FIR testbench

VERILATOR ?= verilator
TOP       ?= fir_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= SIMULATION PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
design/fir_pkg.sv
design/fir_sample_window.sv
design/fir_axil_regs.sv
design/fir_mac_engine.sv
design/fir_top.sv
verification/fir_tb.sv

/* design/fir_axil_regs.sv */
//==============================
// fir_axil_regs: AXI-Lite register block
// control word, length and tap storage
//==============================
`timescale 1ns/10ps

module fir_axil_regs (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic                awvalid,
    input  fir_pkg::addr_t      awaddr,
    output logic                awready,
    input  logic                wvalid,
    input  fir_pkg::data_t      wdata,
    output logic                wready,
    input  logic                arvalid,
    input  fir_pkg::addr_t      araddr,
    output logic                arready,
    output logic                rvalid,
    input  logic                rready,
    output fir_pkg::data_t      rdata,
    input  fir_pkg::fir_event_t evt,
    output fir_pkg::fir_run_t   run,
    input  fir_pkg::tap_idx_t   tap_idx,
    output fir_pkg::data_t      tap_coef
);

    fir_pkg::ap_ctrl_u ctrl_q;
    fir_pkg::ap_ctrl_u ctrl_wr;
    fir_pkg::data_t    length_q;
    fir_pkg::data_t    taps [fir_pkg::NUM_TAPS];
    fir_pkg::addr_t    wr_addr_q;
    fir_pkg::data_t    rd_word;
    logic              wr_phase;
    logic              rd_phase;
    logic              rd_ctrl_q;
    logic              launch_q;
    logic              aw_xfer;
    logic              w_xfer;
    logic              ar_xfer;
    logic              r_xfer;
    logic              start_req;
    logic              cfg_write;

    // word-aligned address inside the tap window
    function automatic logic tap_hit(input fir_pkg::addr_t a);
        return (a >= fir_pkg::REG_TAP_BASE)
            && (a < fir_pkg::REG_TAP_BASE + 4 * fir_pkg::NUM_TAPS)
            && (a[1:0] == 2'b00);
    endfunction

    function automatic fir_pkg::tap_idx_t tap_slot(input fir_pkg::addr_t a);
        return fir_pkg::tap_idx_t'((a - fir_pkg::REG_TAP_BASE) >> 2);
    endfunction

    // write channel, address phase then data phase
    assign awready = !wr_phase;
    assign wready  = wr_phase;
    assign aw_xfer = awvalid && awready;
    assign w_xfer  = wvalid && wready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_phase <= 1'b0;
        end else if (aw_xfer) begin
            wr_phase <= 1'b1;
        end else if (w_xfer) begin
            wr_phase <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (aw_xfer) begin
            wr_addr_q <= awaddr;
        end
    end

    always_comb begin
        ctrl_wr.raw = wdata;
    end

    assign start_req = w_xfer && (wr_addr_q == fir_pkg::REG_CTRL)
                    && ctrl_wr.bits.start && ctrl_q.bits.idle;
    // config only changes between runs
    assign cfg_write = w_xfer && ctrl_q.bits.idle;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctrl_q.raw <= fir_pkg::CTRL_RESET;
            launch_q   <= 1'b0;
            length_q   <= '0;
        end else begin
            launch_q <= start_req;
            if (start_req) begin
                ctrl_q.bits.start <= 1'b1;
                ctrl_q.bits.idle  <= 1'b0;
                ctrl_q.bits.done  <= 1'b0;
            end
            if (evt.first_taken) begin
                ctrl_q.bits.start <= 1'b0;
            end
            // a finished read of the control word consumes done
            if (r_xfer && rd_ctrl_q) begin
                ctrl_q.bits.done <= 1'b0;
            end
            if (evt.frame_done) begin
                ctrl_q.bits.done <= 1'b1;
                ctrl_q.bits.idle <= 1'b1;
            end
            if (cfg_write && (wr_addr_q == fir_pkg::REG_LENGTH)) begin
                length_q <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (cfg_write && tap_hit(wr_addr_q)) begin
            taps[tap_slot(wr_addr_q)] <= wdata;
        end
    end

    assign run.launch = launch_q;
    assign run.length = length_q;
    assign tap_coef   = (tap_idx < fir_pkg::NUM_TAPS) ? taps[tap_idx] : '0;

    // read channel, data captured at the address transfer
    assign arready = !rd_phase;
    assign rvalid  = rd_phase;
    assign ar_xfer = arvalid && arready;
    assign r_xfer  = rvalid && rready;

    always_comb begin
        if (araddr == fir_pkg::REG_CTRL) begin
            rd_word = ctrl_q.raw;
        end else if (araddr == fir_pkg::REG_LENGTH) begin
            rd_word = length_q;
        end else if (tap_hit(araddr)) begin
            rd_word = taps[tap_slot(araddr)];
        end else begin
            rd_word = '0;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_phase  <= 1'b0;
            rd_ctrl_q <= 1'b0;
        end else if (ar_xfer) begin
            rd_phase  <= 1'b1;
            rd_ctrl_q <= (araddr == fir_pkg::REG_CTRL);
        end else if (r_xfer) begin
            rd_phase <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ar_xfer) begin
            rdata <= rd_word;
        end
    end

    a_aw_w_exclusive: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !(awready && wready));

    a_rvalid_hold: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* design/fir_mac_engine.sv */
//==============================
// fir_mac_engine: sample accept, 11-cycle MAC
// and output stream with frame counting
//==============================
`timescale 1ns/10ps

module fir_mac_engine (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  fir_pkg::fir_run_t     run,
    output fir_pkg::fir_event_t   evt,
    input  logic                  ss_tvalid,
    input  fir_pkg::data_t        ss_tdata,
    output logic                  ss_tready,
    input  logic                  sm_tready,
    output logic                  sm_tvalid,
    output fir_pkg::stream_beat_t sm_beat,
    output fir_pkg::tap_idx_t     tap_idx,
    input  fir_pkg::data_t        tap_coef,
    output logic                  win_push,
    output logic                  win_clear,
    output fir_pkg::data_t        win_data,
    output fir_pkg::tap_idx_t     win_age,
    input  fir_pkg::data_t        win_sample
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_IN,
        CALC,
        EMIT
    } eng_state_t;

    eng_state_t        state;
    fir_pkg::tap_idx_t idx;
    fir_pkg::data_t    acc;
    fir_pkg::data_t    product;
    fir_pkg::data_t    out_count;
    logic              first_pend;
    logic              ss_xfer;
    logic              sm_xfer;
    logic              last_out;
    logic              calc_end;

    // one sample in flight, input only opens with the output slot empty
    assign ss_tready = (state == WAIT_IN);
    assign sm_tvalid = (state == EMIT);
    assign ss_xfer   = ss_tvalid && ss_tready;
    assign sm_xfer   = sm_tvalid && sm_tready;

    assign win_clear = (state == IDLE) && run.launch;
    assign win_push  = ss_xfer;
    assign win_data  = ss_tdata;

    // same index walks taps and sample ages
    assign tap_idx  = idx;
    assign win_age  = idx;
    assign product  = tap_coef * win_sample;
    assign calc_end = (state == CALC) && (idx == fir_pkg::NUM_TAPS);
    assign last_out = (out_count + 32'd1) == run.length;

    assign evt.first_taken = ss_xfer && first_pend;
    assign evt.frame_done  = sm_xfer && sm_beat.last;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state      <= IDLE;
            idx        <= '0;
            out_count  <= '0;
            first_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run.launch) begin
                        state      <= WAIT_IN;
                        out_count  <= '0;
                        first_pend <= 1'b1;
                    end
                end
                WAIT_IN: begin
                    if (ss_xfer) begin
                        state      <= CALC;
                        idx        <= '0;
                        first_pend <= 1'b0;
                    end
                end
                CALC: begin
                    if (calc_end) begin
                        state <= EMIT;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                EMIT: begin
                    if (sm_xfer) begin
                        out_count <= out_count + 32'd1;
                        state     <= sm_beat.last ? IDLE : WAIT_IN;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ss_xfer) begin
            acc <= '0;
        end else if ((state == CALC) && !calc_end) begin
            acc <= acc + product;
        end
    end

    // output beat loads one cycle after the last tap
    always_ff @(posedge axis_clk) begin
        if (calc_end) begin
            sm_beat.data <= acc;
            sm_beat.last <= last_out;
        end
    end

    a_beat_hold: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_beat));

    a_no_accept_pending: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid));

endmodule

/* design/fir_pkg.sv */
//==============================
// fir_pkg: widths, register map and shared types
// for the 11-tap FIR filter
//==============================
package fir_pkg;

    // widths
    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 32;
    localparam int NUM_TAPS  = 11;
    localparam int TAP_IDX_W = 4;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;

    // register map, tap i at REG_TAP_BASE + 4*i
    localparam addr_t REG_CTRL     = 12'h000;
    localparam addr_t REG_LENGTH   = 12'h010;
    localparam addr_t REG_TAP_BASE = 12'h020;

    // control word after reset: idle set, done and start clear
    localparam data_t CTRL_RESET = 32'h0000_0004;

    // ap control bits as seen in the control word
    typedef struct packed {
        logic [28:0] pad;
        logic        idle;
        logic        done;
        logic        start;
    } ap_ctrl_bits_t;

    // raw bus word or decoded control bits
    typedef union packed {
        data_t         raw;
        ap_ctrl_bits_t bits;
    } ap_ctrl_u;

    // run request, register block to engine
    typedef struct packed {
        logic  launch;
        data_t length;
    } fir_run_t;

    // run progress, engine to register block
    typedef struct packed {
        logic first_taken;
        logic frame_done;
    } fir_event_t;

    // one output stream beat
    typedef struct packed {
        data_t data;
        logic  last;
    } stream_beat_t;

endpackage

/* design/fir_sample_window.sv */
//==============================
// fir_sample_window: circular store of
// the last 11 input samples, read by age
//==============================
`timescale 1ns/10ps

module fir_sample_window (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              win_push,
    input  logic              win_clear,
    input  fir_pkg::data_t    win_data,
    input  fir_pkg::tap_idx_t win_age,
    output fir_pkg::data_t    win_sample
);

    fir_pkg::data_t    samples [fir_pkg::NUM_TAPS];
    fir_pkg::tap_idx_t head;
    fir_pkg::tap_idx_t next_slot;
    fir_pkg::tap_idx_t rd_slot;

    // head points at the newest sample
    assign next_slot = (head == fir_pkg::NUM_TAPS - 1) ? '0 : head + 1'b1;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            head <= '0;
        end else if (win_push) begin
            head <= next_slot;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (win_clear) begin
            for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
                samples[i] <= '0;
            end
        end else if (win_push) begin
            samples[next_slot] <= win_data;
        end
    end

    // age 0 is the head, older samples wrap backwards
    always_comb begin
        if (win_age <= head) begin
            rd_slot = head - win_age;
        end else begin
            rd_slot = fir_pkg::tap_idx_t'(head + fir_pkg::NUM_TAPS - win_age);
        end
    end

    assign win_sample = (win_age < fir_pkg::NUM_TAPS) ? samples[rd_slot] : '0;

    a_push_clear_excl: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !(win_push && win_clear));

endmodule

/* design/fir_top.sv */
//==============================
// fir_top: 11-tap FIR with AXI-Lite
// config and AXI-Stream data path
//==============================
`timescale 1ns/10ps

module fir_top (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  fir_pkg::addr_t        awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  fir_pkg::data_t        wdata,
    input  logic                  arvalid,
    output logic                  arready,
    input  fir_pkg::addr_t        araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output fir_pkg::data_t        rdata,
    input  logic                  ss_tvalid,
    output logic                  ss_tready,
    input  fir_pkg::data_t        ss_tdata,
    // frame end comes from the length register instead
    input  logic                  ss_tlast,
    output logic                  sm_tvalid,
    input  logic                  sm_tready,
    output fir_pkg::stream_beat_t sm_beat
);

    fir_pkg::fir_run_t   run;
    fir_pkg::fir_event_t evt;
    fir_pkg::tap_idx_t   tap_idx;
    fir_pkg::data_t      tap_coef;
    logic                win_push;
    logic                win_clear;
    fir_pkg::data_t      win_data;
    fir_pkg::tap_idx_t   win_age;
    fir_pkg::data_t      win_sample;

    fir_axil_regs i_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .evt        (evt),
        .run        (run),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef)
    );

    fir_sample_window i_window (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .win_push   (win_push),
        .win_clear  (win_clear),
        .win_data   (win_data),
        .win_age    (win_age),
        .win_sample (win_sample)
    );

    fir_mac_engine i_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .run        (run),
        .evt        (evt),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_beat    (sm_beat),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef),
        .win_push   (win_push),
        .win_clear  (win_clear),
        .win_data   (win_data),
        .win_age    (win_age),
        .win_sample (win_sample)
    );

endmodule

/* verification/fir_tb.sv */
//==============================
// fir_tb: FIR filter testbench with a
// reference model and checking assertions
//==============================
`timescale 1ns/10ps

module fir_tb;

    logic                  axis_clk   = 1'b0;
    logic                  axis_rst_n = 1'b0;
    logic                  awvalid    = 1'b0;
    logic                  awready;
    fir_pkg::addr_t        awaddr     = '0;
    logic                  wvalid     = 1'b0;
    logic                  wready;
    fir_pkg::data_t        wdata      = '0;
    logic                  arvalid    = 1'b0;
    logic                  arready;
    fir_pkg::addr_t        araddr     = '0;
    logic                  rvalid;
    logic                  rready     = 1'b0;
    fir_pkg::data_t        rdata;
    logic                  ss_tvalid  = 1'b0;
    logic                  ss_tready;
    fir_pkg::data_t        ss_tdata   = '0;
    logic                  ss_tlast   = 1'b0;
    logic                  sm_tvalid;
    logic                  sm_tready  = 1'b0;
    fir_pkg::stream_beat_t sm_beat;

    integer         seed        = 21852;
    int             error_count = 0;
    int             reads_done  = 0;
    int             beats_seen  = 0;
    int             cycles      = 0;
    int             run_base    = 0;
    int             run_len     = 0;
    int             frame_end   = 0;
    logic           launched    = 1'b0;
    logic           exp_last    = 1'b0;
    fir_pkg::data_t exp_data    = '0;
    fir_pkg::data_t rd_expect   = '0;
    fir_pkg::data_t tap_vals [fir_pkg::NUM_TAPS];
    fir_pkg::data_t hist [$];

    fir_top i_dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_beat    (sm_beat)
    );

    initial begin
        forever #50 axis_clk = ~axis_clk;
    end

    // sum of taps times older samples, anything before the run counts as zero
    function automatic fir_pkg::data_t expected_output(input int n);
        fir_pkg::data_t sum;
        sum = '0;
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            if (n - i >= run_base) begin
                sum = sum + tap_vals[i] * hist[n - i];
            end
        end
        return sum;
    endfunction

    task automatic write_reg(input fir_pkg::addr_t addr, input fir_pkg::data_t data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        // handshakes are looked at on the falling edge
        @(negedge axis_clk);
        while (!awready) @(negedge axis_clk);
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b1;
        wdata   <= data;
        @(negedge axis_clk);
        while (!wready) @(negedge axis_clk);
        @(posedge axis_clk);
        wvalid <= 1'b0;
    endtask

    task automatic check_read(input fir_pkg::addr_t addr, input fir_pkg::data_t expect_val);
        @(posedge axis_clk);
        arvalid   <= 1'b1;
        araddr    <= addr;
        rready    <= 1'b1;
        rd_expect <= expect_val;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        arvalid <= 1'b0;
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        reads_done = reads_done + 1;
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic load_taps();
        fir_pkg::addr_t addr;
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            tap_vals[i] = $random(seed);
            addr = fir_pkg::REG_TAP_BASE + fir_pkg::addr_t'(4 * i);
            write_reg(addr, tap_vals[i]);
        end
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            addr = fir_pkg::REG_TAP_BASE + fir_pkg::addr_t'(4 * i);
            check_read(addr, tap_vals[i]);
        end
    endtask

    task automatic feed_samples(input int count);
        int gap;
        for (int n = 0; n < count; n++) begin
            gap = $random(seed) & 3;
            repeat (gap) @(posedge axis_clk);
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= $random(seed);
            ss_tlast  <= (n == count - 1);
            @(negedge axis_clk);
            while (!ss_tready) @(negedge axis_clk);
            @(posedge axis_clk);
            ss_tvalid <= 1'b0;
            ss_tlast  <= 1'b0;
        end
    endtask

    task automatic run_frame(input int len);
        write_reg(fir_pkg::REG_LENGTH, len);
        check_read(fir_pkg::REG_LENGTH, len);
        load_taps();
        run_base  = hist.size();
        run_len   = len;
        frame_end = beats_seen + len;
        launched  = 1'b1;
        write_reg(fir_pkg::REG_CTRL, 32'h0000_0001);
        feed_samples(len);
        wait (beats_seen == frame_end);
        // done and idle set, start clear
        check_read(fir_pkg::REG_CTRL, 32'h0000_0006);
        // done consumed by the previous read
        check_read(fir_pkg::REG_CTRL, 32'h0000_0004);
    endtask

    // reference model and output counting
    always @(negedge axis_clk) begin
        if (axis_rst_n) begin
            if (ss_tvalid && ss_tready) begin
                hist.push_back(ss_tdata);
                exp_data = expected_output(hist.size() - 1);
                exp_last = ((hist.size() - run_base) == run_len);
            end
            if (sm_tvalid && sm_tready) begin
                beats_seen = beats_seen + 1;
            end
        end
    end

    // random stalls on the output side
    always @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            sm_tready <= 1'b0;
        end else begin
            sm_tready <= ($random(seed) % 3) != 0;
        end
    end

    // two 16-sample frames with stalls and register traffic stay well below this
    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("timeout: run did not finish within 4000 cycles");
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    a_quiet_before_run: assert property (
        @(negedge axis_clk) disable iff (!axis_rst_n)
        !launched |-> !sm_tvalid && !ss_tready)
        else begin
            error_count = error_count + 1;
            $display("stream handshake active before any run at %0t", $time);
        end

    a_rdata: assert property (
        @(negedge axis_clk) disable iff (!axis_rst_n)
        rvalid |-> rdata == rd_expect)
        else begin
            error_count = error_count + 1;
            $display("Error at %0t: rdata expected %h actual %h", $time, rd_expect, rdata);
        end

    a_beat_data: assert property (
        @(negedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid |-> sm_beat.data == exp_data)
        else begin
            error_count = error_count + 1;
            $display("Error at %0t: sm_beat.data expected %h actual %h",
                     $time, exp_data, sm_beat.data);
        end

    a_beat_last: assert property (
        @(negedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid |-> sm_beat.last == exp_last)
        else begin
            error_count = error_count + 1;
            $display("Error at %0t: sm_beat.last expected %b actual %b",
                     $time, exp_last, sm_beat.last);
        end

    a_beat_stall: assert property (
        @(negedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_beat))
        else begin
            error_count = error_count + 1;
            $display("output beat dropped or changed during a stall at %0t", $time);
        end

    a_input_blocked: assert property (
        @(negedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid |-> !ss_tready)
        else begin
            error_count = error_count + 1;
            $display("input accepted while an output was pending at %0t", $time);
        end

    initial begin
        repeat (2) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
        repeat (2) @(posedge axis_clk);
        // idle set, done and start clear
        check_read(fir_pkg::REG_CTRL, 32'h0000_0004);
        run_frame(16);
        // fresh taps, window cleared at launch
        run_frame(16);
        repeat (4) @(posedge axis_clk);
        $display("checked %0d output beats and %0d register reads, %0d errors",
                 beats_seen, reads_done, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
